// File: Makefile
TOP = tb_aud_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: src/aud_ctrl.sv
`timescale 1ns/10ps

module aud_ctrl (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_key_rec,
    input  logic           i_key_play,
    input  logic           i_key_pause,
    input  logic           i_key_stop,
    sram_if.slave          rec_bus,
    sram_if.slave          play_bus,
    input  logic           i_rec_done,
    input  logic           i_play_done,
    output logic           o_rec_start,
    output logic           o_rec_pause,
    output logic           o_rec_stop,
    output logic           o_play_start,
    output logic           o_play_pause,
    output logic           o_play_stop,
    output mem_pkg::addr_t o_words,
    output mem_pkg::addr_t o_sram_addr,
    output mem_pkg::word_t o_sram_wdata,
    output logic           o_sram_we,
    input  mem_pkg::word_t i_sram_rdata,
    output aud_pkg::mode_t o_mode
);

    aud_pkg::mode_t mode_r, mode_w;
    mem_pkg::addr_t words_r;

    logic in_idle;
    logic in_rec;
    logic in_play;

    assign in_idle = (mode_r == aud_pkg::MODE_IDLE);
    assign in_rec  = (mode_r == aud_pkg::MODE_REC);
    assign in_play = (mode_r == aud_pkg::MODE_PLAY);

    ////////////////////////////////////////
    // Key routing
    ////////////////////////////////////////

    // Record has priority if both keys arrive together
    assign o_rec_start  = in_idle && i_key_rec;
    assign o_play_start = in_idle && !i_key_rec && i_key_play && (words_r != '0);

    assign o_rec_pause  = in_rec && i_key_pause;
    assign o_rec_stop   = in_rec && i_key_stop;
    assign o_play_pause = in_play && i_key_pause;
    assign o_play_stop  = in_play && i_key_stop;

    always_comb begin
        mode_w = mode_r;
        if (o_rec_start) begin
            mode_w = aud_pkg::MODE_REC;
        end else if (o_play_start) begin
            mode_w = aud_pkg::MODE_PLAY;
        end else if ((in_rec && i_rec_done) || (in_play && i_play_done)) begin
            mode_w = aud_pkg::MODE_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            mode_r  <= aud_pkg::MODE_IDLE;
            words_r <= '0;
        end else begin
            mode_r <= mode_w;
            // Count restarts with every new recording
            if (o_rec_start) begin
                words_r <= '0;
            end else if (in_rec && rec_bus.we) begin
                words_r <= words_r + 1'b1;
            end
        end
    end

    assign o_words = words_r;
    assign o_mode  = mode_r;

    ////////////////////////////////////////
    // SRAM bus multiplexer
    ////////////////////////////////////////

    always_comb begin
        o_sram_addr  = '0;
        o_sram_wdata = '0;
        o_sram_we    = 1'b0;
        if (in_rec) begin
            o_sram_addr  = rec_bus.addr;
            o_sram_wdata = rec_bus.wdata;
            o_sram_we    = rec_bus.we;
        end else if (in_play) begin
            o_sram_addr  = play_bus.addr;
            o_sram_wdata = play_bus.wdata;
            o_sram_we    = play_bus.we;
        end
    end

    assign rec_bus.rdata  = i_sram_rdata;
    assign play_bus.rdata = i_sram_rdata;

endmodule

// File: src/aud_pkg.sv
package aud_pkg;

    ////////////////////////////////////////
    // Framing of one left-channel word
    ////////////////////////////////////////

    localparam int SAMPLE_BITS = 16;
    localparam int DELAY_SLOTS = 1;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [4:0]             bit_cnt_t;

    // Slot counter values that bracket the data bits of a word
    localparam bit_cnt_t FIRST_SLOT = bit_cnt_t'(DELAY_SLOTS);
    localparam bit_cnt_t LAST_SLOT  = bit_cnt_t'(DELAY_SLOTS + SAMPLE_BITS - 1);

    ////////////////////////////////////////
    // State machines
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_REC,
        MODE_PLAY
    } mode_t;

    // Shared by the recorder and the player
    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_HIGH,
        S_WAIT_FALL,
        S_SHIFT,
        S_COMMIT,
        S_PAUSE
    } unit_state_t;

endpackage

// File: src/aud_player.sv
`timescale 1ns/10ps

module aud_player (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_start,
    input  logic           i_pause,
    input  logic           i_stop,
    input  logic           i_lrc,
    input  mem_pkg::addr_t i_words,
    sram_if.master         bus,
    output logic           o_dacdat,
    output logic           o_done
);

    aud_pkg::unit_state_t state_r, state_w;
    aud_pkg::bit_cnt_t    cnt_r, cnt_w;
    aud_pkg::sample_t     shift_r, shift_w;
    mem_pkg::addr_t       addr_r, addr_w;
    logic                 dac_r, dac_w;
    logic                 done_r, done_w;

    // Read only
    assign bus.we    = 1'b0;
    assign bus.wdata = '0;
    assign bus.addr  = addr_r;

    assign o_dacdat = dac_r;
    assign o_done   = done_r;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_w = state_r;
        cnt_w   = cnt_r;
        shift_w = shift_r;
        addr_w  = addr_r;
        dac_w   = 1'b0;
        done_w  = 1'b0;

        if (state_r == aud_pkg::S_COMMIT) begin
            addr_w = addr_r + 1'b1;
        end

        case (state_r)
            aud_pkg::S_IDLE: begin
                if (i_start) begin
                    state_w = aud_pkg::S_WAIT_HIGH;
                    addr_w  = '0;
                end
            end
            aud_pkg::S_WAIT_HIGH: begin
                if (i_lrc) begin
                    state_w = aud_pkg::S_WAIT_FALL;
                end
            end
            aud_pkg::S_WAIT_FALL: begin
                // Word clock fall, take the stored word for this frame
                if (!i_lrc) begin
                    state_w = aud_pkg::S_SHIFT;
                    cnt_w   = '0;
                    shift_w = aud_pkg::sample_t'(bus.rdata);
                end
            end
            aud_pkg::S_SHIFT: begin
                if (cnt_r >= aud_pkg::FIRST_SLOT) begin
                    dac_w   = shift_r[aud_pkg::SAMPLE_BITS-1];
                    shift_w = {shift_r[aud_pkg::SAMPLE_BITS-2:0], 1'b0};
                end
                cnt_w = cnt_r + 1'b1;
                if (cnt_r == aud_pkg::LAST_SLOT) begin
                    state_w = aud_pkg::S_COMMIT;
                end
            end
            aud_pkg::S_COMMIT: begin
                if (addr_w == i_words) begin
                    state_w = aud_pkg::S_IDLE;
                    done_w  = 1'b1;
                end else begin
                    state_w = aud_pkg::S_WAIT_HIGH;
                end
            end
            aud_pkg::S_PAUSE: begin
                if (i_pause) begin
                    state_w = aud_pkg::S_WAIT_HIGH;
                end
            end
            default: begin
                state_w = aud_pkg::S_IDLE;
            end
        endcase

        // A cut word is abandoned and the line goes quiet at once
        if (state_r != aud_pkg::S_IDLE) begin
            if (i_stop) begin
                state_w = aud_pkg::S_IDLE;
                done_w  = 1'b1;
                dac_w   = 1'b0;
            end else if (i_pause && state_r != aud_pkg::S_PAUSE &&
                         state_w != aud_pkg::S_IDLE) begin
                state_w = aud_pkg::S_PAUSE;
                dac_w   = 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= aud_pkg::S_IDLE;
            cnt_r   <= '0;
            addr_r  <= '0;
            dac_r   <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            cnt_r   <= cnt_w;
            addr_r  <= addr_w;
            dac_r   <= dac_w;
            done_r  <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

// File: src/aud_recorder.sv
`timescale 1ns/10ps

module aud_recorder #(
    parameter int REC_WORDS = mem_pkg::MAX_WORDS
) (
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_start,
    input  logic   i_pause,
    input  logic   i_stop,
    input  logic   i_lrc,
    input  logic   i_adcdat,
    sram_if.master bus,
    output logic   o_done
);

    localparam mem_pkg::addr_t REC_LIMIT = mem_pkg::addr_t'(REC_WORDS);

    aud_pkg::unit_state_t state_r, state_w;
    aud_pkg::bit_cnt_t    cnt_r, cnt_w;
    aud_pkg::sample_t     shift_r, shift_w;
    mem_pkg::addr_t       addr_r, addr_w;
    logic                 done_r, done_w;

    // The write pulse is the commit cycle itself
    assign bus.we    = (state_r == aud_pkg::S_COMMIT);
    assign bus.addr  = addr_r;
    assign bus.wdata = mem_pkg::word_t'(shift_r);
    assign o_done    = done_r;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_w = state_r;
        cnt_w   = cnt_r;
        shift_w = shift_r;
        addr_w  = addr_r;
        done_w  = 1'b0;

        // A committed word always advances the address, even when cut short below
        if (state_r == aud_pkg::S_COMMIT) begin
            addr_w = addr_r + 1'b1;
        end

        case (state_r)
            aud_pkg::S_IDLE: begin
                if (i_start) begin
                    state_w = aud_pkg::S_WAIT_HIGH;
                    addr_w  = '0;
                end
            end
            aud_pkg::S_WAIT_HIGH: begin
                if (i_lrc) begin
                    state_w = aud_pkg::S_WAIT_FALL;
                end
            end
            aud_pkg::S_WAIT_FALL: begin
                // Cycle 0 of the word
                if (!i_lrc) begin
                    state_w = aud_pkg::S_SHIFT;
                    cnt_w   = '0;
                end
            end
            aud_pkg::S_SHIFT: begin
                if (cnt_r >= aud_pkg::FIRST_SLOT) begin
                    shift_w = {shift_r[aud_pkg::SAMPLE_BITS-2:0], i_adcdat};
                end
                cnt_w = cnt_r + 1'b1;
                if (cnt_r == aud_pkg::LAST_SLOT) begin
                    state_w = aud_pkg::S_COMMIT;
                end
            end
            aud_pkg::S_COMMIT: begin
                if (addr_w == REC_LIMIT) begin
                    state_w = aud_pkg::S_IDLE;
                    done_w  = 1'b1;
                end else begin
                    state_w = aud_pkg::S_WAIT_HIGH;
                end
            end
            aud_pkg::S_PAUSE: begin
                if (i_pause) begin
                    state_w = aud_pkg::S_WAIT_HIGH;
                end
            end
            default: begin
                state_w = aud_pkg::S_IDLE;
            end
        endcase

        // Stop and pause drop whatever part of a word is in the shifter
        if (state_r != aud_pkg::S_IDLE) begin
            if (i_stop) begin
                state_w = aud_pkg::S_IDLE;
                done_w  = 1'b1;
            end else if (i_pause && state_r != aud_pkg::S_PAUSE &&
                         state_w != aud_pkg::S_IDLE) begin
                state_w = aud_pkg::S_PAUSE;
            end
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= aud_pkg::S_IDLE;
            cnt_r   <= '0;
            addr_r  <= '0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            cnt_r   <= cnt_w;
            addr_r  <= addr_w;
            done_r  <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

// File: src/aud_top.sv
`timescale 1ns/10ps

module aud_top #(
    parameter int REC_WORDS = mem_pkg::MAX_WORDS
) (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_key_rec,
    input  logic           i_key_play,
    input  logic           i_key_pause,
    input  logic           i_key_stop,
    input  logic           i_lrc,
    input  logic           i_adcdat,
    output logic           o_dacdat,
    output mem_pkg::addr_t o_sram_addr,
    output mem_pkg::word_t o_sram_wdata,
    output logic           o_sram_we,
    input  mem_pkg::word_t i_sram_rdata,
    output aud_pkg::mode_t o_mode,
    output mem_pkg::addr_t o_rec_words
);

    sram_if rec_bus ();
    sram_if play_bus ();

    logic rec_start, rec_pause, rec_stop, rec_done;
    logic play_start, play_pause, play_stop, play_done;

    aud_ctrl ctrl0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_key_rec    (i_key_rec),
        .i_key_play   (i_key_play),
        .i_key_pause  (i_key_pause),
        .i_key_stop   (i_key_stop),
        .rec_bus      (rec_bus.slave),
        .play_bus     (play_bus.slave),
        .i_rec_done   (rec_done),
        .i_play_done  (play_done),
        .o_rec_start  (rec_start),
        .o_rec_pause  (rec_pause),
        .o_rec_stop   (rec_stop),
        .o_play_start (play_start),
        .o_play_pause (play_pause),
        .o_play_stop  (play_stop),
        .o_words      (o_rec_words),
        .o_sram_addr  (o_sram_addr),
        .o_sram_wdata (o_sram_wdata),
        .o_sram_we    (o_sram_we),
        .i_sram_rdata (i_sram_rdata),
        .o_mode       (o_mode)
    );

    aud_recorder #(
        .REC_WORDS (REC_WORDS)
    ) rec0 (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (rec_start),
        .i_pause  (rec_pause),
        .i_stop   (rec_stop),
        .i_lrc    (i_lrc),
        .i_adcdat (i_adcdat),
        .bus      (rec_bus.master),
        .o_done   (rec_done)
    );

    aud_player play0 (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (play_start),
        .i_pause  (play_pause),
        .i_stop   (play_stop),
        .i_lrc    (i_lrc),
        .i_words  (o_rec_words),
        .bus      (play_bus.master),
        .o_dacdat (o_dacdat),
        .o_done   (play_done)
    );

endmodule

// File: src/mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////
    // External asynchronous SRAM
    ////////////////////////////////////////

    localparam int ADDR_BITS = 20;
    localparam int WORD_BITS = 16;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [WORD_BITS-1:0] word_t;

    // Buffer capacity in words, must stay below 2**ADDR_BITS
    localparam int MAX_WORDS = 1024000;

endpackage

// File: src/sram_if.sv
`timescale 1ns/10ps

// One unit's view of the SRAM bus
interface sram_if;

    mem_pkg::addr_t addr;
    mem_pkg::word_t wdata;
    logic           we;
    // Combinational read data for the current addr
    mem_pkg::word_t rdata;

    modport master (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

// File: verif/aud_chk.sv
`timescale 1ns/10ps

module aud_chk (
    input logic           i_clk,
    input logic           i_rst_n,
    input logic           i_sram_we,
    input mem_pkg::addr_t i_sram_addr,
    input logic           i_dacdat,
    input aud_pkg::mode_t i_mode
);

    ////////////////////////////////////////
    // SRAM bus
    ////////////////////////////////////////

    a_we_in_rec: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_sram_we |-> i_mode == aud_pkg::MODE_REC)
        else $error("SRAM write outside recording");

    a_we_single: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_sram_we |=> !i_sram_we)
        else $error("SRAM write held for two cycles");

    a_addr_idle: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_mode == aud_pkg::MODE_IDLE |-> i_sram_addr == '0)
        else $error("SRAM address not zero while idle");

    // DAC line stays quiet unless playing
    a_dac_quiet: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_mode != aud_pkg::MODE_PLAY |-> !i_dacdat)
        else $error("DAC data active outside playback");

endmodule

bind aud_top aud_chk chk0 (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_sram_we   (o_sram_we),
    .i_sram_addr (o_sram_addr),
    .i_dacdat    (o_dacdat),
    .i_mode      (o_mode)
);

// File: verif/tb_aud_top.sv
`timescale 1ns/10ps

module tb_aud_top;

    localparam int REC_WORDS = 24;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [3:0] keys;
    logic lrc, adcdat, dacdat, sram_we;
    mem_pkg::addr_t sram_addr, rec_words;
    mem_pkg::word_t sram_wdata, sram_rdata;
    aud_pkg::mode_t mode;

    logic [15:0] mem_arr [0:63];
    logic [15:0] mem_model [0:63];
    logic [15:0] adc_word, play_word;
    int s = 39, cycles = 0, err_val = 0, err_other = 0, nwr = 0;
    int m_mode = 0, m_addr = 0, m_count = 0, frame_mode = 0;
    int stop_cycle = 0;
    bit m_paused = 0, frame_ok = 0, wr_seen = 0;

    aud_top #(.REC_WORDS(REC_WORDS)) dut0 (
        .i_clk(clk), .i_rst_n(rst),
        .i_key_rec(keys[0]), .i_key_play(keys[1]), .i_key_pause(keys[2]), .i_key_stop(keys[3]),
        .i_lrc(lrc), .i_adcdat(adcdat), .o_dacdat(dacdat),
        .o_sram_addr(sram_addr), .o_sram_wdata(sram_wdata), .o_sram_we(sram_we),
        .i_sram_rdata(sram_rdata), .o_mode(mode), .o_rec_words(rec_words)
    );

    always #5 clk = ~clk;

    assign sram_rdata = mem_arr[sram_addr[5:0]];

    ////////////////////////////////////////
    // Codec model, one 40-slot frame
    ////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("Timeout: the run did not finish within 20000 cycles");
            $display("Test failures found");
            $finish;
        end
        s = (s == 39) ? 0 : s + 1;
        if (s == 0) begin
            adc_word = 16'($urandom);
            play_word = mem_model[m_addr];
            frame_mode = m_mode;
            frame_ok = (m_mode != 0) && !m_paused;
            wr_seen = 0;
        end
        lrc <= (s >= 20);
        // MSB is taken by the recorder two edges after the fall is seen
        adcdat <= (s >= 2 && s <= 17) ? adc_word[17-s] : 1'b0;
    end

    ////////////////////////////////////////
    // Scoreboard and SRAM writes
    ////////////////////////////////////////

    always @(negedge clk) begin
        logic exp_dac;
        exp_dac = 1'b0;
        if (frame_ok && frame_mode == 2 && s >= 3 && s <= 18)
            exp_dac = play_word[18-s];
        if (!rst && dacdat !== exp_dac) begin
            $display("** Error %0t: DAC bit %b, expected %b at slot %0d", $time,
                     dacdat, exp_dac, s);
            err_val++;
        end
        if (sram_we === 1'b1) begin
            nwr++;
            mem_arr[sram_addr[5:0]] = sram_wdata;
            if (!(frame_ok && frame_mode == 1 && s == 18)) begin
                $display("%0t: a write happened where no whole word was recorded", $time);
                err_other++;
            end else if (sram_addr != mem_pkg::addr_t'(m_addr) || sram_wdata != adc_word) begin
                $display("** Error %0t: write %h to %0d, expected %h to %0d", $time,
                         sram_wdata, sram_addr, adc_word, m_addr);
                err_val++;
            end
            wr_seen = 1;
        end
        if (s == 20 && frame_ok && frame_mode == m_mode && m_mode != 0) begin
            if (m_mode == 1) begin
                if (!wr_seen) begin
                    $display("%0t: the word of a whole frame was not written", $time);
                    err_other++;
                end
                mem_model[m_addr] = adc_word;
                m_addr++;
                m_count = m_addr;
                if (m_addr == REC_WORDS) m_mode = 0;
            end else begin
                m_addr++;
                if (m_addr == m_count) m_mode = 0;
            end
        end
    end

    task automatic wait_slot(input int slot);
        do @(negedge clk); while (s != slot);
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (mode != aud_pkg::MODE_IDLE);
    endtask

    function automatic int high_slot();
        return 21 + int'($urandom_range(15));
    endfunction

    // Applies the key rules to the model, then pulses the key
    task automatic key_action(input int key, input int slot);
        wait_slot(slot);
        case (key)
            0: if (m_mode == 0) begin
                m_mode = 1;
                m_addr = 0;
                m_count = 0;
            end
            1: if (m_mode == 0 && m_count != 0) begin
                m_mode = 2;
                m_addr = 0;
            end
            2: if (m_mode != 0) begin
                if (!m_paused && slot <= 16) frame_ok = 0;
                m_paused = !m_paused;
            end
            default: if (m_mode != 0) begin
                m_mode = 0;
                m_paused = 0;
            end
        endcase
        @(posedge clk);
        keys[key] <= 1'b1;
        @(posedge clk);
        keys <= '0;
        // Back at a falling edge once the DUT has taken the key
        @(negedge clk);
    endtask

    task automatic expect_state(input aud_pkg::mode_t exp_mode, input int exp_words);
        if (mode != exp_mode || rec_words != mem_pkg::addr_t'(exp_words)) begin
            $display("** Error %0t: mode %0d words %0d, expected mode %0d words %0d",
                     $time, mode, rec_words, exp_mode, exp_words);
            err_val++;
        end
    endtask

    initial begin
        void'($urandom(32'h8d8d));
        keys = '0;
        lrc = 1'b1;
        adcdat = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_arr[i] = 16'(i * 16'h3c1) ^ 16'ha5a5;
            mem_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Record ten frames with a play key that must be ignored
        key_action(0, high_slot());
        repeat (5) wait_slot(0);
        key_action(1, high_slot());
        if (mode != aud_pkg::MODE_REC) begin
            $display("%0t: play key changed the mode during recording", $time);
            err_other++;
        end
        repeat (5) wait_slot(0);
        key_action(3, high_slot());
        wait_idle();
        expect_state(aud_pkg::MODE_IDLE, m_count);

        // Pause cuts a word, then recording resumes at the next address
        key_action(0, high_slot());
        repeat (4) wait_slot(0);
        key_action(2, 5 + int'($urandom_range(9)));
        repeat (3) wait_slot(0);
        key_action(2, high_slot());
        repeat (4) wait_slot(0);
        key_action(3, high_slot());
        wait_idle();
        expect_state(aud_pkg::MODE_IDLE, m_count);

        // Full buffer ends the session by itself
        nwr = 0;
        key_action(0, high_slot());
        wait_idle();
        if (nwr != REC_WORDS) begin
            $display("%0t: %0d words were written instead of %0d", $time, nwr, REC_WORDS);
            err_other++;
        end
        expect_state(aud_pkg::MODE_IDLE, REC_WORDS);

        // Whole playback
        key_action(1, high_slot());
        wait_idle();
        expect_state(aud_pkg::MODE_IDLE, REC_WORDS);

        // Pause, ignored record key and early stop during playback
        key_action(1, high_slot());
        repeat (3) wait_slot(0);
        key_action(2, high_slot());
        repeat (2) wait_slot(0);
        key_action(2, high_slot());
        repeat (2) wait_slot(0);
        key_action(0, high_slot());
        expect_state(aud_pkg::MODE_PLAY, REC_WORDS);
        key_action(3, high_slot());
        stop_cycle = cycles;
        wait_idle();
        if (cycles - stop_cycle > 1) begin
            $display("%0t: playback did not end right after the stop key", $time);
            err_other++;
        end
        expect_state(aud_pkg::MODE_IDLE, REC_WORDS);
        for (int i = 0; i < REC_WORDS; i++) begin
            if (mem_arr[i] != mem_model[i]) begin
                $display("** Error %0t: SRAM word %0d is %h, expected %h", $time, i,
                         mem_arr[i], mem_model[i]);
                err_val++;
            end
        end

        $display("Done: %0d value errors, %0d other errors", err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/aud_pkg.sv
src/mem_pkg.sv
src/sram_if.sv
src/aud_recorder.sv
src/aud_player.sv
src/aud_ctrl.sv
src/aud_top.sv
verif/aud_chk.sv
verif/tb_aud_top.sv
